//--- files.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/fetch_stage.sv
rtl/decode_unit.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/execute_alu.sv
rtl/data_master.sv
rtl/core.sv
testbench/clock_gen.sv
testbench/tb_core.sv

//--- Bender.yml
package:
  name: rv32i_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rv_pkg.sv
      - rtl/fetch_stage.sv
      - rtl/decode_unit.sv
      - rtl/reg_file.sv
      - rtl/hazard_unit.sv
      - rtl/execute_alu.sv
      - rtl/data_master.sv
      - rtl/core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/clock_gen.sv
      - testbench/tb_core.sv

//--- testbench/tb_core.sv
`default_nettype none
`include "rv_config.svh"

module tb_core;

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] MARKER_ADDR = 32'h0000_03FC; // store here ends a program
	localparam int MAX_CYCLES = 4 * 150 * 4 + 5 * 16; // four 150-instruction programs at 4x plus resets

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0] be;
		logic [31:0] data;
	} store_rec_t;

	logic clk, rst_n;
	logic restart = 1'b0;
	rv_pkg::word_t inst_addr;
	rv_pkg::word_t inst_data = `RV_NOP;
	logic inst_stall;
	rv_pkg::word_t avl_address, avl_writedata;
	rv_pkg::word_t avl_readdata = '0;
	rv_pkg::byte_en_t avl_byteenable;
	logic avl_read, avl_write;
	logic avl_waitrequest = 1'b1; // idle slave holds off until it accepts

	logic [31:0] rom [0:255]; // instruction words
	logic [31:0] dmem [0:255]; // data words by byte address bits 9:2
	store_rec_t store_log[$]; // committed writes in order
	logic [31:0] wait_state = 32'd24426; // xorshift seed
	logic [69:0] req_snapshot;
	logic req_held = 1'b0;
	bit random_wait = 1'b0;
	int marker_count = 0;
	int pc_next; // byte address of the next emitted instruction
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	clock_gen clk0 (.restart(restart), .clk(clk), .rst_n(rst_n));

	core dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.inst_addr(inst_addr),
		.inst_data(inst_data),
		.inst_stall(inst_stall),
		.avl_address(avl_address),
		.avl_byteenable(avl_byteenable),
		.avl_read(avl_read),
		.avl_readdata(avl_readdata),
		.avl_waitrequest(avl_waitrequest),
		.avl_write(avl_write),
		.avl_writedata(avl_writedata)
	);

	// ##################################################
	// memory models
	always @(posedge clk) begin
		if (!inst_stall) begin
			inst_data <= rom[inst_addr[7:0]]; // one cycle read held on stall
		end
	end

	always @(posedge clk) begin
		logic [69:0] req_now;
		req_now = {avl_address, avl_byteenable, avl_writedata, avl_read, avl_write};
		wait_state = xorshift32(wait_state);
		if (rst_n && req_held && req_now !== req_snapshot) begin
			errors++;
			$display("** Error at %0d ns: avalon request is %h, expected %h", $time,
				req_now, req_snapshot);
		end
		if (rst_n && (avl_read || avl_write) && avl_waitrequest && !inst_stall) begin
			errors++;
			$display("Instruction stall was low at %0d ns while a data access waited",
				$time);
		end
		req_held <= 1'b0;
		if (!rst_n) begin
			avl_waitrequest <= 1'b1;
		end else if ((avl_read || avl_write) && avl_waitrequest) begin
			req_snapshot <= req_now; // must hold until accepted
			req_held <= 1'b1;
			if (!(random_wait && wait_state % 3 == 0)) begin
				avl_waitrequest <= 1'b0; // complete next cycle
				avl_readdata <= dmem[avl_address[9:2]];
			end
		end else begin
			avl_waitrequest <= 1'b1;
			if (avl_write && !avl_waitrequest) begin
				for (int b = 0; b < 4; b++) begin
					if (avl_byteenable[b]) begin
						dmem[avl_address[9:2]][8 * b +: 8] = avl_writedata[8 * b +: 8];
					end
				end
				store_log.push_back({avl_address, avl_byteenable, avl_writedata});
				if (avl_address == MARKER_ADDR) begin
					marker_count <= marker_count + 1;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, a program never reached its end marker", cycles);
			$display("%0d checks, %0d errors", checks, errors);
			$display("Some tests failed");
			$finish;
		end
	end

	// ##################################################
	// helpers
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	function automatic logic [31:0] fill_word(input int i);
		return (32'(i) * 32'h9E37_79B9) ^ 32'hA5A5_0000; // differs in every index bit
	endfunction

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input int off);
		logic [12:0] o;
		o = off[12:0];
		return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(input logic [4:0] rd, input int off);
		logic [20:0] o;
		o = off[20:0];
		return {o[20], o[10:1], o[11], o[19:12], rd, 7'b1101111};
	endfunction

	task automatic emit(input logic [31:0] instr);
		rom[pc_next >> 2] = instr;
		pc_next += 4;
	endtask

	task automatic end_program();
		emit(s_type(3'b010, 0, 0, MARKER_ADDR[11:0])); // end marker
		emit(j_type(0, 0)); // spin here
	endtask

	task automatic clear_rom();
		for (int i = 0; i < 256; i++) begin
			rom[i] = `RV_NOP;
		end
		pc_next = 0;
	endtask

	task automatic fill_dmem();
		for (int i = 0; i < 256; i++) begin
			dmem[i] = fill_word(i);
		end
		store_log.delete();
	endtask

	task automatic start_reset();
		@(posedge clk);
		restart <= 1'b1;
		@(posedge clk);
		restart <= 1'b0;
		@(posedge clk); // core now held in reset
	endtask

	task automatic run_to_marker();
		int goal;
		while (!rst_n) @(posedge clk);
		goal = marker_count + 1;
		while (marker_count < goal) @(posedge clk);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// ##################################################
	// directed tests
	task automatic reset_outputs();
		start_reset();
		clear_rom();
		fill_dmem();
		while (!rst_n) begin
			check_value("avl_read", 32'(avl_read), 0);
			check_value("avl_write", 32'(avl_write), 0);
			check_value("inst_addr", inst_addr, `RV_RESET_PC >> 2);
			@(posedge clk);
		end
		check_value("inst_addr", inst_addr, `RV_RESET_PC >> 2); // first fetch
		repeat (8) begin
			@(posedge clk);
			check_value("avl_read", 32'(avl_read), 0); // only nops so far
			check_value("avl_write", 32'(avl_write), 0);
		end
	endtask

	task automatic alu_chain(input bit with_waits);
		logic [31:0] e [1:9];
		logic [31:0] pc_auipc;
		store_rec_t exp_log[$];
		random_wait = with_waits;
		start_reset();
		clear_rom();
		emit(i_type(rv_pkg::OP_IMM, 3'b000, 1, 0, 12'h123)); // addi x1,x0,0x123
		emit(u_type(rv_pkg::OP_LUI, 2, 20'hABCDE));
		emit(r_type(7'h00, 3'b000, 3, 1, 2)); // add
		emit(r_type(7'h20, 3'b000, 4, 3, 1)); // sub
		emit(r_type(7'h00, 3'b100, 5, 4, 3)); // xor
		emit(r_type(7'h00, 3'b010, 6, 2, 5)); // slt of negative against positive
		emit(r_type(7'h00, 3'b001, 7, 3, 6)); // sll by x6
		emit(i_type(rv_pkg::OP_IMM, 3'b101, 8, 2, 12'h408)); // srai x8,x2,8
		pc_auipc = pc_next;
		emit(u_type(rv_pkg::OP_AUIPC, 9, 20'h00001));
		for (int k = 1; k <= 9; k++) begin
			emit(s_type(3'b010, 0, k, 12'(4 * k))); // sw xk, 4k(x0)
		end
		end_program();
		fill_dmem();
		e[1] = 32'h0000_0123;
		e[2] = {20'hABCDE, 12'h000};
		e[3] = e[1] + e[2];
		e[4] = e[3] - e[1];
		e[5] = e[4] ^ e[3];
		e[6] = ($signed(e[2]) < $signed(e[5])) ? 32'd1 : 32'd0;
		e[7] = e[3] << e[6][4:0];
		e[8] = $signed(e[2]) >>> 8;
		e[9] = pc_auipc + 32'h0000_1000;
		for (int k = 1; k <= 9; k++) begin
			exp_log.push_back({32'(4 * k), 4'b1111, e[k]});
		end
		exp_log.push_back({MARKER_ADDR, 4'b1111, 32'h0000_0000}); // sw x0 marker
		run_to_marker();
		for (int k = 1; k <= 9; k++) begin
			check_value($sformatf("dmem[%0d]", k), dmem[k], e[k]);
		end
		check_value("dmem[0]", dmem[0], fill_word(0)); // untouched
		check_value("store count", store_log.size(), exp_log.size());
		for (int i = 0; i < store_log.size() && i < exp_log.size(); i++) begin
			check_value($sformatf("store %0d address", i), store_log[i].addr,
				exp_log[i].addr);
			check_value($sformatf("store %0d data", i), store_log[i].data,
				exp_log[i].data);
			check_value($sformatf("store %0d byteenable", i), 32'(store_log[i].be),
				32'(exp_log[i].be));
		end
		random_wait = 1'b0;
	endtask

	task automatic branch_jump();
		int loop1, loop2, jal_pc, jalr_pc;
		start_reset();
		clear_rom();
		emit(i_type(rv_pkg::OP_IMM, 3'b000, 1, 0, 12'd0));
		emit(i_type(rv_pkg::OP_IMM, 3'b000, 2, 0, 12'd5)); // loop limit
		loop1 = pc_next;
		emit(i_type(rv_pkg::OP_IMM, 3'b000, 1, 1, 12'd1));
		emit(b_type(3'b001, 1, 2, loop1 - pc_next)); // bne needing x1 from execute
		emit(i_type(rv_pkg::OP_IMM, 3'b000, 3, 0, 12'd0));
		loop2 = pc_next;
		emit(i_type(rv_pkg::OP_IMM, 3'b000, 3, 3, 12'd1));
		emit(b_type(3'b100, 3, 2, loop2 - pc_next)); // blt
		emit(b_type(3'b111, 2, 1, 8)); // bgeu 5 >= 5 taken
		emit(i_type(rv_pkg::OP_IMM, 3'b000, 10, 0, 12'd99)); // skipped
		jal_pc = pc_next;
		emit(j_type(5, 12));
		emit(i_type(rv_pkg::OP_IMM, 3'b000, 10, 0, 12'd98)); // flushed slot
		emit(s_type(3'b010, 0, 2, 12'd20)); // skipped store
		emit(i_type(rv_pkg::OP_IMM, 3'b000, 6, 0, 12'(pc_next + 16))); // jalr target
		jalr_pc = pc_next;
		emit(i_type(rv_pkg::OP_JALR, 3'b000, 7, 6, 12'd0));
		emit(i_type(rv_pkg::OP_IMM, 3'b000, 10, 0, 12'd96)); // flushed slot
		emit(s_type(3'b010, 0, 2, 12'd24));
		emit(s_type(3'b010, 0, 1, 12'd0));
		emit(s_type(3'b010, 0, 3, 12'd4));
		emit(s_type(3'b010, 0, 5, 12'd8));
		emit(s_type(3'b010, 0, 7, 12'd12));
		emit(s_type(3'b010, 0, 10, 12'd16));
		end_program();
		fill_dmem();
		run_to_marker();
		check_value("bne loop count", dmem[0], 32'd5);
		check_value("blt loop count", dmem[1], 32'd5);
		check_value("jal link", dmem[2], jal_pc + 4);
		check_value("jalr link", dmem[3], jalr_pc + 4);
		check_value("x10 after skipped writes", dmem[4], 32'd0);
		check_value("dmem[5]", dmem[5], fill_word(5)); // no skipped store
		check_value("dmem[6]", dmem[6], fill_word(6));
	endtask

	task automatic byte_lanes();
		logic [31:0] v;
		logic [31:0] w18;
		logic [31:0] f17, f18, f19;
		start_reset();
		clear_rom();
		emit(u_type(rv_pkg::OP_LUI, 1, 20'h89ABD));
		emit(i_type(rv_pkg::OP_IMM, 3'b000, 1, 1, 12'hDEF)); // addi -0x211
		emit(s_type(3'b010, 0, 1, 12'h040)); // sw
		emit(s_type(3'b000, 0, 1, 12'h045)); // sb lane 1
		emit(s_type(3'b001, 0, 1, 12'h04A)); // sh upper half
		emit(s_type(3'b000, 0, 1, 12'h04F)); // sb lane 3
		emit(i_type(rv_pkg::OP_LOAD, 3'b000, 2, 0, 12'h041)); // lb
		emit(i_type(rv_pkg::OP_LOAD, 3'b100, 3, 0, 12'h043)); // lbu
		emit(i_type(rv_pkg::OP_LOAD, 3'b001, 4, 0, 12'h042)); // lh
		emit(i_type(rv_pkg::OP_LOAD, 3'b101, 5, 0, 12'h040)); // lhu
		emit(i_type(rv_pkg::OP_LOAD, 3'b010, 6, 0, 12'h048)); // lw
		for (int k = 2; k <= 6; k++) begin
			emit(s_type(3'b010, 0, k, 12'(12'h048 + 4 * k))); // words 20..24
		end
		end_program();
		fill_dmem();
		v = {20'h89ABD, 12'h000} + {{20{1'b1}}, 12'hDEF};
		f17 = fill_word(17);
		f18 = fill_word(18);
		f19 = fill_word(19);
		w18 = {v[15:0], f18[15:0]}; // sh into the upper half
		run_to_marker();
		check_value("dmem[16]", dmem[16], v);
		check_value("dmem[17]", dmem[17], {f17[31:16], v[7:0], f17[7:0]});
		check_value("dmem[18]", dmem[18], w18);
		check_value("dmem[19]", dmem[19], {v[7:0], f19[23:0]});
		check_value("lb", dmem[20], {{24{v[15]}}, v[15:8]});
		check_value("lbu", dmem[21], {24'h0, v[31:24]});
		check_value("lh", dmem[22], {{16{v[31]}}, v[31:16]});
		check_value("lhu", dmem[23], {16'h0, v[15:0]});
		check_value("lw", dmem[24], w18);
		if (store_log.size() < 4) begin
			errors++;
			$display("Fewer stores than expected reached the data bus");
		end else begin
			check_value("sw byteenable", 32'(store_log[0].be), 32'b1111);
			check_value("sb byteenable", 32'(store_log[1].be), 32'b0010);
			check_value("sh byteenable", 32'(store_log[2].be), 32'b1100);
			check_value("sb byteenable", 32'(store_log[3].be), 32'b1000);
			check_value("sb address", store_log[1].addr, 32'h0000_0044);
			check_value("sb lane", 32'(store_log[1].data[15:8]), 32'(v[7:0]));
			check_value("sh lane", 32'(store_log[2].data[31:16]), 32'(v[15:0]));
		end
	endtask

	initial begin
		reset_outputs();
		alu_chain(1'b0);
		branch_jump();
		byte_lanes();
		alu_chain(1'b1); // same program under random waitrequest
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
`default_nettype none

module clock_gen #(
	parameter int PERIOD = 40, // ns
	parameter int RESET_CYCLES = 16
) (
	input wire logic restart, // sampled on the rising edge
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	int count = 0; // cycles since the last reset request

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		if (restart) begin
			count <= 0; // start a new reset window
		end else if (count != RESET_CYCLES) begin
			count <= count + 1;
		end
	end

	assign rst_n = (count == RESET_CYCLES); // low for the whole window

endmodule

`default_nettype wire

//--- rtl/core.sv
`default_nettype none

module core (
	input wire logic clk,
	input wire logic rst_n,
	// instruction master
	output rv_pkg::word_t inst_addr,
	input wire rv_pkg::word_t inst_data,
	output logic inst_stall,
	// avalon data master
	output rv_pkg::word_t avl_address,
	output rv_pkg::byte_en_t avl_byteenable,
	output logic avl_read,
	input wire rv_pkg::word_t avl_readdata,
	input wire logic avl_waitrequest,
	output logic avl_write,
	output rv_pkg::word_t avl_writedata
);

	rv_pkg::word_t id_instr, id_pc; // decode slot
	rv_pkg::word_t target;
	rv_pkg::word_t rs1_raw, rs2_raw; // register file reads
	rv_pkg::word_t rs1_val, rs2_val; // after decode forwarding
	rv_pkg::word_t load_data, rd_data;
	rv_pkg::reg_addr_t rs1_addr, rs2_addr;
	rv_pkg::id_ex_t id_ex_d, id_ex_q;
	rv_pkg::ex_mem_t ex_mem_d, ex_mem_q;
	logic redirect, uses_rs_early;
	logic br_stall, mem_stall;
	logic ex_fwd_a, ex_fwd_b;
	logic reg_we;

	assign inst_stall = br_stall || mem_stall; // memory holds inst_data

	// ##################################################
	// fetch and decode
	fetch_stage fetch0 (
		.clk(clk),
		.rst_n(rst_n),
		.stall(inst_stall),
		.redirect(redirect),
		.target(target),
		.inst_addr(inst_addr),
		.inst_data(inst_data),
		.id_instr(id_instr),
		.id_pc(id_pc)
	);

	reg_file regs0 (
		.clk(clk),
		.rst_n(rst_n),
		.we(reg_we),
		.waddr(ex_mem_q.ctrl.rd),
		.wdata(rd_data),
		.raddr_a(rs1_addr),
		.raddr_b(rs2_addr),
		.rdata_a(rs1_raw),
		.rdata_b(rs2_raw)
	);

	hazard_unit hazard0 (
		.id_rs1(rs1_addr),
		.id_rs2(rs2_addr),
		.uses_rs_early(uses_rs_early),
		.ex_rd(id_ex_q.ctrl.rd),
		.ex_reg_write(id_ex_q.ctrl.reg_write),
		.ex_rs1(id_ex_q.rs1),
		.ex_rs2(id_ex_q.rs2),
		.mem_rd(ex_mem_q.ctrl.rd),
		.mem_reg_write(ex_mem_q.ctrl.reg_write),
		.rd_data(rd_data),
		.id_rs1_val_raw(rs1_raw),
		.id_rs2_val_raw(rs2_raw),
		.id_rs1_val(rs1_val),
		.id_rs2_val(rs2_val),
		.ex_fwd_a(ex_fwd_a),
		.ex_fwd_b(ex_fwd_b),
		.br_stall(br_stall)
	);

	decode_unit decode0 (
		.id_instr(id_instr),
		.id_pc(id_pc),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val),
		.id_ex(id_ex_d),
		.redirect(redirect),
		.target(target),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.uses_rs_early(uses_rs_early)
	);

	// ##################################################
	// decode/execute, bubble on a branch stall
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex_q <= '0;
		end else if (!mem_stall) begin
			id_ex_q <= id_ex_d;
			if (br_stall) begin
				id_ex_q.ctrl <= '0; // decode retries next cycle
			end
		end
	end

	execute_alu alu0 (
		.id_ex(id_ex_q),
		.fwd_a(ex_fwd_a),
		.fwd_b(ex_fwd_b),
		.fwd_data(rd_data),
		.ex_mem(ex_mem_d)
	);

	// execute/memory, frozen with everything else on waitrequest
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem_q <= '0; // read/write low until first access
		end else if (!mem_stall) begin
			ex_mem_q <= ex_mem_d;
		end
	end

	// ##################################################
	// memory and writeback
	data_master dmem0 (
		.clk(clk),
		.rst_n(rst_n),
		.ex_mem(ex_mem_q),
		.load_data(load_data),
		.mem_stall(mem_stall),
		.avl_address(avl_address),
		.avl_byteenable(avl_byteenable),
		.avl_read(avl_read),
		.avl_readdata(avl_readdata),
		.avl_waitrequest(avl_waitrequest),
		.avl_write(avl_write),
		.avl_writedata(avl_writedata)
	);

	always_comb begin
		case (ex_mem_q.ctrl.wb_sel)
			rv_pkg::WB_MEM: rd_data = load_data;
			rv_pkg::WB_PC4: rd_data = ex_mem_q.pc + 32'd4; // link value
			default: rd_data = ex_mem_q.result;
		endcase
	end

	assign reg_we = ex_mem_q.ctrl.reg_write && !mem_stall; // one write per instruction

	// decode drops x0 writes, nothing later may bring one back
	a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
		reg_we |-> ex_mem_q.ctrl.rd != '0);

endmodule

`default_nettype wire

//--- rtl/data_master.sv
`default_nettype none

module data_master (
	input wire logic clk,
	input wire logic rst_n,
	input wire rv_pkg::ex_mem_t ex_mem,
	output rv_pkg::word_t load_data,
	output logic mem_stall,
	output rv_pkg::word_t avl_address,
	output rv_pkg::byte_en_t avl_byteenable,
	output logic avl_read,
	input wire rv_pkg::word_t avl_readdata,
	input wire logic avl_waitrequest,
	output logic avl_write,
	output rv_pkg::word_t avl_writedata
);

	logic [1:0] offset; // byte within word
	logic [2:0] funct3;
	logic [7:0] ld_byte;
	logic [15:0] ld_half;

	assign offset = ex_mem.result[1:0];
	assign funct3 = ex_mem.ctrl.mem_funct3;

	// ##################################################
	// request, straight from the execute/memory register
	assign avl_address = {ex_mem.result[31:2], 2'b00}; // word aligned
	assign avl_read = ex_mem.ctrl.mem_read;
	assign avl_write = ex_mem.ctrl.mem_write;
	assign mem_stall = (avl_read || avl_write) && avl_waitrequest;

	always_comb begin
		case (funct3[1:0])
			2'b00: begin
				avl_byteenable = rv_pkg::byte_en_t'(1) << offset; // byte
				avl_writedata = {4{ex_mem.store_data[7:0]}};
			end
			2'b01: begin
				avl_byteenable = rv_pkg::byte_en_t'(3) << {offset[1], 1'b0}; // half
				avl_writedata = {2{ex_mem.store_data[15:0]}};
			end
			default: begin
				avl_byteenable = '1; // word
				avl_writedata = ex_mem.store_data;
			end
		endcase
	end

	// ##################################################
	// load lane pick and extension
	assign ld_byte = avl_readdata[{offset, 3'b000} +: 8];
	assign ld_half = offset[1] ? avl_readdata[31:16] : avl_readdata[15:0];

	always_comb begin
		case (funct3)
			3'b000: load_data = {{24{ld_byte[7]}}, ld_byte}; // lb
			3'b001: load_data = {{16{ld_half[15]}}, ld_half}; // lh
			3'b100: load_data = {24'b0, ld_byte}; // lbu
			3'b101: load_data = {16'b0, ld_half}; // lhu
			default: load_data = avl_readdata; // lw
		endcase
	end

	// the held pipeline must keep the whole request frozen
	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		mem_stall |=> $stable({avl_address, avl_byteenable, avl_writedata,
			avl_read, avl_write}));

endmodule

`default_nettype wire

//--- rtl/execute_alu.sv
`default_nettype none

module execute_alu (
	input wire rv_pkg::id_ex_t id_ex,
	input wire logic fwd_a,
	input wire logic fwd_b,
	input wire rv_pkg::word_t fwd_data,
	output rv_pkg::ex_mem_t ex_mem
);

	rv_pkg::word_t rs1_fwd, rs2_fwd; // operands after forwarding
	rv_pkg::word_t op_a, op_b;
	rv_pkg::word_t result;
	logic [4:0] shamt;

	assign rs1_fwd = fwd_a ? fwd_data : id_ex.rs1_val;
	assign rs2_fwd = fwd_b ? fwd_data : id_ex.rs2_val;
	assign op_a = id_ex.ctrl.a_is_pc ? id_ex.pc : rs1_fwd; // auipc
	assign op_b = id_ex.ctrl.b_is_imm ? id_ex.imm : rs2_fwd;
	assign shamt = op_b[4:0];

	always_comb begin
		case (id_ex.ctrl.alu_op)
			rv_pkg::ALU_ADD: result = op_a + op_b;
			rv_pkg::ALU_SUB: result = op_a - op_b;
			rv_pkg::ALU_SLL: result = op_a << shamt;
			rv_pkg::ALU_SLT: result = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
			rv_pkg::ALU_SLTU: result = rv_pkg::word_t'(op_a < op_b);
			rv_pkg::ALU_XOR: result = op_a ^ op_b;
			rv_pkg::ALU_SRL: result = op_a >> shamt;
			rv_pkg::ALU_SRA: result = rv_pkg::word_t'($signed(op_a) >>> shamt);
			rv_pkg::ALU_OR: result = op_a | op_b;
			rv_pkg::ALU_AND: result = op_a & op_b;
			default: result = op_b; // pass b
		endcase
	end

	assign ex_mem = '{
		ctrl: id_ex.ctrl,
		pc: id_ex.pc,
		result: result,
		store_data: rs2_fwd // sw after a dependent op
	};

endmodule

`default_nettype wire

//--- rtl/hazard_unit.sv
`default_nettype none

module hazard_unit (
	input wire rv_pkg::reg_addr_t id_rs1,
	input wire rv_pkg::reg_addr_t id_rs2,
	input wire logic uses_rs_early,
	input wire rv_pkg::reg_addr_t ex_rd,
	input wire logic ex_reg_write,
	input wire rv_pkg::reg_addr_t ex_rs1,
	input wire rv_pkg::reg_addr_t ex_rs2,
	input wire rv_pkg::reg_addr_t mem_rd,
	input wire logic mem_reg_write,
	input wire rv_pkg::word_t rd_data,
	input wire rv_pkg::word_t id_rs1_val_raw,
	input wire rv_pkg::word_t id_rs2_val_raw,
	output rv_pkg::word_t id_rs1_val,
	output rv_pkg::word_t id_rs2_val,
	output logic ex_fwd_a,
	output logic ex_fwd_b,
	output logic br_stall
);

	logic id_fwd_a, id_fwd_b;

	// reg_write is already clear for rd = x0, no zero check needed
	assign id_fwd_a = mem_reg_write && mem_rd == id_rs1;
	assign id_fwd_b = mem_reg_write && mem_rd == id_rs2;
	assign id_rs1_val = id_fwd_a ? rd_data : id_rs1_val_raw; // writeback into decode
	assign id_rs2_val = id_fwd_b ? rd_data : id_rs2_val_raw;

	// execute read its operands one cycle before this result existed
	assign ex_fwd_a = mem_reg_write && mem_rd == ex_rs1;
	assign ex_fwd_b = mem_reg_write && mem_rd == ex_rs2;

	// branch or jalr waits one cycle for the execute result to reach memory
	assign br_stall = uses_rs_early && ex_reg_write &&
		(ex_rd == id_rs1 || ex_rd == id_rs2);

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`default_nettype none
`include "rv_config.svh"

module reg_file (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic we,
	input wire rv_pkg::reg_addr_t waddr,
	input wire rv_pkg::word_t wdata,
	input wire rv_pkg::reg_addr_t raddr_a,
	input wire rv_pkg::reg_addr_t raddr_b,
	output rv_pkg::word_t rdata_a,
	output rv_pkg::word_t rdata_b
);

	rv_pkg::word_t regs [1:`RV_NUM_REGS-1]; // x0 has no storage

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < `RV_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 reads zero, a same-cycle write passes straight through
	assign rdata_a = (raddr_a == '0) ? '0 :
		(we && waddr == raddr_a) ? wdata : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 :
		(we && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

`default_nettype wire

//--- rtl/decode_unit.sv
`default_nettype none

module decode_unit (
	input wire rv_pkg::word_t id_instr,
	input wire rv_pkg::word_t id_pc,
	input wire rv_pkg::word_t rs1_val,
	input wire rv_pkg::word_t rs2_val,
	output rv_pkg::id_ex_t id_ex,
	output logic redirect,
	output rv_pkg::word_t target,
	output rv_pkg::reg_addr_t rs1_addr,
	output rv_pkg::reg_addr_t rs2_addr,
	output logic uses_rs_early
);

	rv_pkg::opcode_e opcode;
	logic [2:0] funct3;
	rv_pkg::reg_addr_t rd;
	rv_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	rv_pkg::word_t imm; // selected immediate
	rv_pkg::ctrl_t ctrl;
	logic br_eq, br_lt, br_ltu, br_taken;

	function automatic rv_pkg::alu_op_e alu_decode(logic [2:0] f3, logic alt);
		case (f3)
			3'b000: return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			3'b001: return rv_pkg::ALU_SLL;
			3'b010: return rv_pkg::ALU_SLT;
			3'b011: return rv_pkg::ALU_SLTU;
			3'b100: return rv_pkg::ALU_XOR;
			3'b101: return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
			3'b110: return rv_pkg::ALU_OR;
			default: return rv_pkg::ALU_AND;
		endcase
	endfunction

	assign opcode = rv_pkg::opcode_e'(id_instr[6:0]);
	assign funct3 = id_instr[14:12];
	assign rd = id_instr[11:7];
	assign rs1_addr = id_instr[19:15];
	assign rs2_addr = id_instr[24:20];

	// ##################################################
	// immediates
	assign imm_i = {{20{id_instr[31]}}, id_instr[31:20]};
	assign imm_s = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
	assign imm_b = {{19{id_instr[31]}}, id_instr[31], id_instr[7], id_instr[30:25],
		id_instr[11:8], 1'b0};
	assign imm_u = {id_instr[31:12], 12'b0};
	assign imm_j = {{11{id_instr[31]}}, id_instr[31], id_instr[19:12], id_instr[20],
		id_instr[30:21], 1'b0};

	// ##################################################
	// branch compare on forwarded operands
	assign br_eq = rs1_val == rs2_val;
	assign br_lt = $signed(rs1_val) < $signed(rs2_val);
	assign br_ltu = rs1_val < rs2_val;

	always_comb begin
		case (funct3)
			3'b000: br_taken = br_eq; // beq
			3'b001: br_taken = !br_eq; // bne
			3'b100: br_taken = br_lt; // blt
			3'b101: br_taken = !br_lt; // bge
			3'b110: br_taken = br_ltu; // bltu
			default: br_taken = !br_ltu; // bgeu
		endcase
	end

	assign target = (opcode == rv_pkg::OP_JALR) ?
		((rs1_val + imm) & ~rv_pkg::word_t'(1)) : id_pc + imm; // jalr drops bit 0

	// ##################################################
	// control decode
	always_comb begin
		ctrl = '0; // add, alu writeback, no side effects
		ctrl.mem_funct3 = funct3;
		ctrl.rd = rd;
		imm = imm_i;
		redirect = 1'b0;
		uses_rs_early = 1'b0;
		case (opcode)
			rv_pkg::OP_LUI: begin
				ctrl.alu_op = rv_pkg::ALU_PASS_B; // rd = imm
				ctrl.b_is_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				imm = imm_u;
			end
			rv_pkg::OP_AUIPC: begin
				ctrl.a_is_pc = 1'b1;
				ctrl.b_is_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				imm = imm_u;
			end
			rv_pkg::OP_JAL: begin
				ctrl.wb_sel = rv_pkg::WB_PC4; // link
				ctrl.reg_write = 1'b1;
				imm = imm_j;
				redirect = 1'b1;
			end
			rv_pkg::OP_JALR: begin
				ctrl.wb_sel = rv_pkg::WB_PC4;
				ctrl.reg_write = 1'b1;
				redirect = 1'b1;
				uses_rs_early = 1'b1; // target needs rs1 here
			end
			rv_pkg::OP_BRANCH: begin
				imm = imm_b;
				redirect = br_taken;
				uses_rs_early = 1'b1;
			end
			rv_pkg::OP_LOAD: begin
				ctrl.b_is_imm = 1'b1; // address = rs1 + imm
				ctrl.mem_read = 1'b1;
				ctrl.wb_sel = rv_pkg::WB_MEM;
				ctrl.reg_write = 1'b1;
			end
			rv_pkg::OP_STORE: begin
				ctrl.b_is_imm = 1'b1;
				ctrl.mem_write = 1'b1;
				imm = imm_s;
			end
			rv_pkg::OP_IMM: begin
				ctrl.alu_op = alu_decode(funct3, funct3 == 3'b101 && id_instr[30]);
				ctrl.b_is_imm = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			rv_pkg::OP_REG: begin
				ctrl.alu_op = alu_decode(funct3, id_instr[30]);
				ctrl.reg_write = 1'b1;
			end
			default: ctrl.rd = '0; // fence, system and unknown
		endcase
		if (rd == '0) begin
			ctrl.reg_write = 1'b0; // x0 writes vanish here
		end
	end

	assign id_ex = '{
		ctrl: ctrl,
		pc: id_pc,
		rs1_val: rs1_val,
		rs2_val: rs2_val,
		imm: imm,
		rs1: rs1_addr,
		rs2: rs2_addr
	};

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
`default_nettype none
`include "rv_config.svh"

module fetch_stage (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic stall,
	input wire logic redirect,
	input wire rv_pkg::word_t target,
	output rv_pkg::word_t inst_addr,
	input wire rv_pkg::word_t inst_data,
	output rv_pkg::word_t id_instr,
	output rv_pkg::word_t id_pc
);

	rv_pkg::word_t pc_q; // byte address being fetched
	logic valid_q; // decode slot holds a real instruction

	assign inst_addr = pc_q >> 2; // memory is word addressed
	assign id_instr = valid_q ? inst_data : `RV_NOP; // flushed slot runs as nop

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= `RV_RESET_PC;
			id_pc <= `RV_RESET_PC;
			valid_q <= 1'b0; // memory output not yet meaningful
		end else if (!stall) begin
			pc_q <= redirect ? target : pc_q + 32'd4;
			id_pc <= pc_q; // pc of the word arriving next cycle
			valid_q <= !redirect; // word in flight is wrong path
		end
	end

	// jalr targets only clear bit 0, so this also catches bad link math
	a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- rtl/rv_pkg.sv
`default_nettype none
`include "rv_config.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0] word_t; // data or address word
	typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t; // x0..x31
	typedef logic [`RV_BYTE_EN_W-1:0] byte_en_t; // avalon byteenable

	// major opcodes, anything else decodes as a no-op
	typedef enum logic [6:0] {
		OP_LOAD   = 7'b0000011,
		OP_IMM    = 7'b0010011,
		OP_AUIPC  = 7'b0010111,
		OP_STORE  = 7'b0100011,
		OP_REG    = 7'b0110011,
		OP_LUI    = 7'b0110111,
		OP_BRANCH = 7'b1100011,
		OP_JALR   = 7'b1100111,
		OP_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD, // zero, so a cleared ctrl adds
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B // lui
	} alu_op_e;

	typedef enum logic [1:0] {
		WB_ALU, // alu result
		WB_MEM, // load data
		WB_PC4  // link address
	} wb_sel_e;

	// ##################################################
	// pipeline payloads
	typedef struct packed {
		alu_op_e alu_op;
		logic a_is_pc; // auipc
		logic b_is_imm; // imm instead of rs2
		logic mem_read;
		logic mem_write;
		logic [2:0] mem_funct3; // access size and sign
		wb_sel_e wb_sel;
		logic reg_write; // never set for rd = x0
		reg_addr_t rd;
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t pc;
		word_t rs1_val; // already forwarded in decode
		word_t rs2_val;
		word_t imm;
		reg_addr_t rs1; // indices for execute forwarding
		reg_addr_t rs2;
	} id_ex_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t pc; // for the link value
		word_t result; // alu result or memory address
		word_t store_data;
	} ex_mem_t;

endpackage

`default_nettype wire

//--- rtl/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// ##################################################
// core widths
`define RV_XLEN       32 // data and address width
`define RV_REG_ADDR_W 5  // register index width
`define RV_NUM_REGS   32 // x0..x31
`define RV_BYTE_EN_W  4  // avalon lanes per word

// ##################################################
// boot and flush values
`define RV_RESET_PC   32'h0000_0000 // first fetched byte address
`define RV_NOP        32'h0000_0013 // addi x0,x0,0

`endif
